// File: include/stripe_consts.svh
`ifndef STRIPE_CONSTS_SVH
`define STRIPE_CONSTS_SVH

// Bank count, must be a power of two
`define STRIPE_NUM_BANKS 2

// Manager word address, beat and id widths
`define STRIPE_ADDR_W 8
`define STRIPE_DATA_W 16
`define STRIPE_ID_W 4

// Bursts that may be outstanding in each path
`define STRIPE_FIFO_DEPTH 4

// Words held by one bank
`define STRIPE_BANK_DEPTH (1 << (`STRIPE_ADDR_W - $clog2(`STRIPE_NUM_BANKS)))

`endif

// File: logic/bank_mem.sv
`include "stripe_consts.svh"

module bank_mem (
  input  logic clk,
  input  logic i_rst,

  input  logic                   i_aw_valid,
  input  stripe_pkg::bank_addr_t i_aw_addr,
  input  stripe_pkg::len_t       i_aw_len,
  output logic                   o_aw_ready,
  input  logic                   i_w_valid,
  input  stripe_pkg::data_t      i_w_data,
  input  logic                   i_w_last,
  output logic                   o_w_ready,
  output logic                   o_b_valid,
  output stripe_pkg::resp_t      o_b_resp,
  input  logic                   i_b_ready,

  input  logic                   i_ar_valid,
  input  stripe_pkg::bank_addr_t i_ar_addr,
  input  stripe_pkg::len_t       i_ar_len,
  output logic                   o_ar_ready,
  output logic                   o_r_valid,
  output stripe_pkg::data_t      o_r_data,
  output logic                   o_r_last,
  input  logic                   i_r_ready
);

  stripe_pkg::data_t      mem[`STRIPE_BANK_DEPTH];

  logic                   wr_active;
  stripe_pkg::bank_addr_t wr_addr;
  stripe_pkg::len_t       wr_left;
  logic                   w_fire;

  logic                   rd_active;
  stripe_pkg::bank_addr_t rd_addr;
  stripe_pkg::len_t       rd_left;

  // Write side is busy from AW until its B is taken
  assign o_aw_ready = !wr_active && !o_b_valid;
  assign o_w_ready  = wr_active;
  assign o_b_resp   = stripe_pkg::OKAY;
  assign w_fire     = i_w_valid && wr_active;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_active <= 1'b0;
      o_b_valid <= 1'b0;
    end else begin
      if (i_aw_valid && o_aw_ready) begin
        wr_active <= 1'b1;
      end else if (w_fire && wr_left == '0) begin
        wr_active <= 1'b0;
        o_b_valid <= 1'b1;
      end else if (o_b_valid && i_b_ready) begin
        o_b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_aw_valid && o_aw_ready) begin
      wr_addr <= i_aw_addr;
      wr_left <= i_aw_len;
    end else if (w_fire) begin
      mem[wr_addr] <= i_w_data;
      wr_addr      <= wr_addr + 1'b1;
      wr_left      <= wr_left - 1'b1;
    end
  end

  // Read side, one beat per cycle straight from the array
  assign o_ar_ready = !rd_active;
  assign o_r_valid  = rd_active;
  assign o_r_data   = mem[rd_addr];
  assign o_r_last   = (rd_left == '0);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_active <= 1'b0;
    end else if (i_ar_valid && o_ar_ready) begin
      rd_active <= 1'b1;
    end else if (rd_active && i_r_ready && o_r_last) begin
      rd_active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_ar_valid && o_ar_ready) begin
      rd_addr <= i_ar_addr;
      rd_left <= i_ar_len;
    end else if (rd_active && i_r_ready) begin
      rd_addr <= rd_addr + 1'b1;
      rd_left <= rd_left - 1'b1;
    end
  end

  a_w_last : assert property (@(posedge clk) disable iff (i_rst)
    w_fire |-> (i_w_last == (wr_left == '0)));

endmodule

// File: logic/burst_fifo.sv
`include "stripe_consts.svh"

module burst_fifo #(
  parameter type payload_t = stripe_pkg::id_t
) (
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_push,
  input  payload_t i_push_data,
  input  logic     i_pop,
  output payload_t o_head,
  output logic     o_empty,
  output logic     o_full
);

  localparam int DEPTH = `STRIPE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  payload_t entries[DEPTH];

  // Extra top bit tells full from empty when the indexes match
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      entries[wr_ptr[PTR_W-1:0]] <= i_push_data;
    end
  end

  assign o_head  = entries[rd_ptr[PTR_W-1:0]];
  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  a_no_overflow : assert property (@(posedge clk) disable iff (i_rst)
    !(i_push && o_full));

  a_no_underflow : assert property (@(posedge clk) disable iff (i_rst)
    !(i_pop && o_empty));

endmodule

// File: logic/stripe_pkg.sv
`include "stripe_consts.svh"

package stripe_pkg;

  localparam int BANK_BITS = $clog2(`STRIPE_NUM_BANKS);

  // Manager side word address
  typedef logic [`STRIPE_ADDR_W-1:0] addr_t;

  // Word address inside one bank, low stripe bits removed
  typedef logic [`STRIPE_ADDR_W-BANK_BITS-1:0] bank_addr_t;

  typedef logic [`STRIPE_DATA_W-1:0] data_t;
  typedef logic [`STRIPE_ID_W-1:0] id_t;

  // Beats minus one, as on AXI
  typedef logic [7:0] len_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

  // Read burst bookkeeping, id plus length for the last beat
  typedef struct packed {
    id_t  id;
    len_t len;
  } rd_burst_t;

endpackage

// File: logic/stripe_rd.sv
`include "stripe_consts.svh"

module stripe_rd (
  input  logic clk,
  input  logic i_rst,

  input  logic                i_ar_valid,
  input  stripe_pkg::addr_t   i_ar_addr,
  input  stripe_pkg::id_t     i_ar_id,
  input  stripe_pkg::len_t    i_ar_len,
  output logic                o_ar_ready,
  output logic                o_r_valid,
  output stripe_pkg::data_t   o_r_data,
  output stripe_pkg::id_t     o_r_id,
  output logic                o_r_last,
  input  logic                i_r_ready,

  output logic [`STRIPE_NUM_BANKS-1:0]                        o_bk_ar_valid,
  output stripe_pkg::bank_addr_t [`STRIPE_NUM_BANKS-1:0]      o_bk_ar_addr,
  output stripe_pkg::len_t [`STRIPE_NUM_BANKS-1:0]            o_bk_ar_len,
  input  logic [`STRIPE_NUM_BANKS-1:0]                        i_bk_ar_ready,
  input  logic [`STRIPE_NUM_BANKS-1:0]                        i_bk_r_valid,
  input  stripe_pkg::data_t [`STRIPE_NUM_BANKS-1:0]           i_bk_r_data,
  input  logic [`STRIPE_NUM_BANKS-1:0]                        i_bk_r_last,
  output logic [`STRIPE_NUM_BANKS-1:0]                        o_bk_r_ready
);

  localparam int N = `STRIPE_NUM_BANKS;
  localparam int SEL_W = $clog2(N);

  logic                   ar_rdy;
  logic                   ar_fire;
  logic [N-1:0]           ar_pend;
  stripe_pkg::bank_addr_t ar_addr_q;
  stripe_pkg::len_t       ar_len_q;

  stripe_pkg::rd_burst_t  push_burst;
  stripe_pkg::rd_burst_t  head;
  stripe_pkg::len_t       r_cnt;
  logic [SEL_W-1:0]       r_sel;
  logic                   r_fire;
  logic                   fifo_empty;
  logic                   fifo_full;

  assign o_ar_ready = ar_rdy;
  assign ar_fire    = i_ar_valid && ar_rdy;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      ar_rdy  <= 1'b0;
      ar_pend <= '0;
      r_cnt   <= '0;
    end else begin
      ar_rdy <= !ar_fire && (ar_pend == '0) && !fifo_full;
      if (ar_fire) begin
        ar_pend <= '1;
      end else begin
        ar_pend <= ar_pend & ~i_bk_ar_ready;
      end
      if (r_fire) begin
        r_cnt <= o_r_last ? '0 : r_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      ar_addr_q <= stripe_pkg::bank_addr_t'(i_ar_addr >> SEL_W);
      ar_len_q  <= i_ar_len >> SEL_W;
    end
  end

  assign o_bk_ar_valid = ar_pend;
  assign o_bk_ar_addr  = {N{ar_addr_q}};
  assign o_bk_ar_len   = {N{ar_len_q}};

  // Banks finish bursts in order, so the beat count picks the serving bank
  assign r_sel     = r_cnt[SEL_W-1:0];
  assign o_r_valid = i_bk_r_valid[r_sel];
  assign o_r_data  = i_bk_r_data[r_sel];
  assign o_r_id    = head.id;
  assign o_r_last  = (r_cnt == head.len);
  assign r_fire    = o_r_valid && i_r_ready;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      o_bk_r_ready[i] = i_r_ready && (r_sel == SEL_W'(i));
    end
  end

  assign push_burst.id  = i_ar_id;
  assign push_burst.len = i_ar_len;

  burst_fifo #(
    .payload_t(stripe_pkg::rd_burst_t)
  ) burst_fifo_i (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_push     (ar_fire),
    .i_push_data(push_burst),
    .i_pop      (r_fire && o_r_last),
    .o_head     (head),
    .o_empty    (fifo_empty),
    .o_full     (fifo_full)
  );

  a_ar_aligned : assert property (@(posedge clk) disable iff (i_rst)
    i_ar_valid |-> (i_ar_addr[SEL_W-1:0] == '0) && (i_ar_len[SEL_W-1:0] == '1));

  // Bank side last must land in the final stripe of the head burst
  a_bank_last : assert property (@(posedge clk) disable iff (i_rst)
    o_r_valid |-> !fifo_empty && (i_bk_r_last[r_sel] == (r_cnt >= head.len - 8'(N - 1))));

endmodule

// File: logic/stripe_top.sv
`include "stripe_consts.svh"

module stripe_top (
  input  logic              clk,
  input  logic              i_rst,

  input  logic              i_aw_valid,
  input  stripe_pkg::addr_t i_aw_addr,
  input  stripe_pkg::id_t   i_aw_id,
  input  stripe_pkg::len_t  i_aw_len,
  output logic              o_aw_ready,
  input  logic              i_w_valid,
  input  stripe_pkg::data_t i_w_data,
  input  logic              i_w_last,
  output logic              o_w_ready,
  output logic              o_b_valid,
  output stripe_pkg::id_t   o_b_id,
  output stripe_pkg::resp_t o_b_resp,
  input  logic              i_b_ready,

  input  logic              i_ar_valid,
  input  stripe_pkg::addr_t i_ar_addr,
  input  stripe_pkg::id_t   i_ar_id,
  input  stripe_pkg::len_t  i_ar_len,
  output logic              o_ar_ready,
  output logic              o_r_valid,
  output stripe_pkg::data_t o_r_data,
  output stripe_pkg::id_t   o_r_id,
  output logic              o_r_last,
  input  logic              i_r_ready
);

  localparam int N = `STRIPE_NUM_BANKS;

  // Per-bank write channels
  logic [N-1:0]                     bk_aw_valid;
  stripe_pkg::bank_addr_t [N-1:0]   bk_aw_addr;
  stripe_pkg::len_t [N-1:0]         bk_aw_len;
  logic [N-1:0]                     bk_aw_ready;
  logic [N-1:0]                     bk_w_valid;
  stripe_pkg::data_t [N-1:0]        bk_w_data;
  logic [N-1:0]                     bk_w_last;
  logic [N-1:0]                     bk_w_ready;
  logic [N-1:0]                     bk_b_valid;
  stripe_pkg::resp_t [N-1:0]        bk_b_resp;
  logic [N-1:0]                     bk_b_ready;

  // Per-bank read channels
  logic [N-1:0]                     bk_ar_valid;
  stripe_pkg::bank_addr_t [N-1:0]   bk_ar_addr;
  stripe_pkg::len_t [N-1:0]         bk_ar_len;
  logic [N-1:0]                     bk_ar_ready;
  logic [N-1:0]                     bk_r_valid;
  stripe_pkg::data_t [N-1:0]        bk_r_data;
  logic [N-1:0]                     bk_r_last;
  logic [N-1:0]                     bk_r_ready;

  stripe_wr stripe_wr_i (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_aw_valid   (i_aw_valid),
    .i_aw_addr    (i_aw_addr),
    .i_aw_id      (i_aw_id),
    .i_aw_len     (i_aw_len),
    .o_aw_ready   (o_aw_ready),
    .i_w_valid    (i_w_valid),
    .i_w_data     (i_w_data),
    .i_w_last     (i_w_last),
    .o_w_ready    (o_w_ready),
    .o_b_valid    (o_b_valid),
    .o_b_id       (o_b_id),
    .o_b_resp     (o_b_resp),
    .i_b_ready    (i_b_ready),
    .o_bk_aw_valid(bk_aw_valid),
    .o_bk_aw_addr (bk_aw_addr),
    .o_bk_aw_len  (bk_aw_len),
    .i_bk_aw_ready(bk_aw_ready),
    .o_bk_w_valid (bk_w_valid),
    .o_bk_w_data  (bk_w_data),
    .o_bk_w_last  (bk_w_last),
    .i_bk_w_ready (bk_w_ready),
    .i_bk_b_valid (bk_b_valid),
    .i_bk_b_resp  (bk_b_resp),
    .o_bk_b_ready (bk_b_ready)
  );

  stripe_rd stripe_rd_i (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_ar_valid   (i_ar_valid),
    .i_ar_addr    (i_ar_addr),
    .i_ar_id      (i_ar_id),
    .i_ar_len     (i_ar_len),
    .o_ar_ready   (o_ar_ready),
    .o_r_valid    (o_r_valid),
    .o_r_data     (o_r_data),
    .o_r_id       (o_r_id),
    .o_r_last     (o_r_last),
    .i_r_ready    (i_r_ready),
    .o_bk_ar_valid(bk_ar_valid),
    .o_bk_ar_addr (bk_ar_addr),
    .o_bk_ar_len  (bk_ar_len),
    .i_bk_ar_ready(bk_ar_ready),
    .i_bk_r_valid (bk_r_valid),
    .i_bk_r_data  (bk_r_data),
    .i_bk_r_last  (bk_r_last),
    .o_bk_r_ready (bk_r_ready)
  );

  for (genvar i = 0; i < N; i++) begin : gen_bank
    bank_mem bank_mem_i (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_aw_valid(bk_aw_valid[i]),
      .i_aw_addr (bk_aw_addr[i]),
      .i_aw_len  (bk_aw_len[i]),
      .o_aw_ready(bk_aw_ready[i]),
      .i_w_valid (bk_w_valid[i]),
      .i_w_data  (bk_w_data[i]),
      .i_w_last  (bk_w_last[i]),
      .o_w_ready (bk_w_ready[i]),
      .o_b_valid (bk_b_valid[i]),
      .o_b_resp  (bk_b_resp[i]),
      .i_b_ready (bk_b_ready[i]),
      .i_ar_valid(bk_ar_valid[i]),
      .i_ar_addr (bk_ar_addr[i]),
      .i_ar_len  (bk_ar_len[i]),
      .o_ar_ready(bk_ar_ready[i]),
      .o_r_valid (bk_r_valid[i]),
      .o_r_data  (bk_r_data[i]),
      .o_r_last  (bk_r_last[i]),
      .i_r_ready (bk_r_ready[i])
    );
  end

endmodule

// File: logic/stripe_wr.sv
`include "stripe_consts.svh"

module stripe_wr (
  input  logic clk,
  input  logic i_rst,

  input  logic                i_aw_valid,
  input  stripe_pkg::addr_t   i_aw_addr,
  input  stripe_pkg::id_t     i_aw_id,
  input  stripe_pkg::len_t    i_aw_len,
  output logic                o_aw_ready,
  input  logic                i_w_valid,
  input  stripe_pkg::data_t   i_w_data,
  input  logic                i_w_last,
  output logic                o_w_ready,
  output logic                o_b_valid,
  output stripe_pkg::id_t     o_b_id,
  output stripe_pkg::resp_t   o_b_resp,
  input  logic                i_b_ready,

  output logic [`STRIPE_NUM_BANKS-1:0]                        o_bk_aw_valid,
  output stripe_pkg::bank_addr_t [`STRIPE_NUM_BANKS-1:0]      o_bk_aw_addr,
  output stripe_pkg::len_t [`STRIPE_NUM_BANKS-1:0]            o_bk_aw_len,
  input  logic [`STRIPE_NUM_BANKS-1:0]                        i_bk_aw_ready,
  output logic [`STRIPE_NUM_BANKS-1:0]                        o_bk_w_valid,
  output stripe_pkg::data_t [`STRIPE_NUM_BANKS-1:0]           o_bk_w_data,
  output logic [`STRIPE_NUM_BANKS-1:0]                        o_bk_w_last,
  input  logic [`STRIPE_NUM_BANKS-1:0]                        i_bk_w_ready,
  input  logic [`STRIPE_NUM_BANKS-1:0]                        i_bk_b_valid,
  input  stripe_pkg::resp_t [`STRIPE_NUM_BANKS-1:0]           i_bk_b_resp,
  output logic [`STRIPE_NUM_BANKS-1:0]                        o_bk_b_ready
);

  localparam int N = `STRIPE_NUM_BANKS;
  localparam int SEL_W = $clog2(N);

  logic                   aw_rdy;
  logic                   aw_fire;
  logic [N-1:0]           aw_pend;
  stripe_pkg::bank_addr_t aw_addr_q;
  stripe_pkg::len_t       aw_len_q;

  logic                   w_active;
  logic                   w_fire;
  stripe_pkg::len_t       w_cnt;
  stripe_pkg::len_t       w_len;
  logic [SEL_W-1:0]       w_sel;

  logic [N-1:0]           b_done;
  stripe_pkg::resp_t      resp_q;
  logic                   b_fire;
  logic                   fifo_empty;
  logic                   fifo_full;

  assign o_aw_ready = aw_rdy;
  assign aw_fire    = i_aw_valid && aw_rdy;

  // Ready is registered, so it can only be granted from a settled state
  always_ff @(posedge clk) begin
    if (i_rst) begin
      aw_rdy   <= 1'b0;
      aw_pend  <= '0;
      w_active <= 1'b0;
      w_cnt    <= '0;
    end else begin
      aw_rdy <= !aw_fire && (aw_pend == '0) && !w_active && !fifo_full;
      if (aw_fire) begin
        aw_pend  <= '1;
        w_active <= 1'b1;
      end else begin
        aw_pend <= aw_pend & ~i_bk_aw_ready;
      end
      if (w_fire) begin
        w_cnt <= i_w_last ? '0 : w_cnt + 1'b1;
        if (i_w_last) begin
          w_active <= 1'b0;
        end
      end
    end
  end

  // Same bank request for every bank, length in bank beats
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_addr_q <= stripe_pkg::bank_addr_t'(i_aw_addr >> SEL_W);
      aw_len_q  <= i_aw_len >> SEL_W;
      w_len     <= i_aw_len;
    end
  end

  assign o_bk_aw_valid = aw_pend;
  assign o_bk_aw_addr  = {N{aw_addr_q}};
  assign o_bk_aw_len   = {N{aw_len_q}};

  // Beats go round robin; the final stripe carries each bank's last beat
  assign w_sel     = w_cnt[SEL_W-1:0];
  assign o_w_ready = i_bk_w_ready[w_sel];
  assign w_fire    = i_w_valid && o_w_ready;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      o_bk_w_valid[i] = i_w_valid && (w_sel == SEL_W'(i));
      o_bk_w_data[i]  = i_w_data;
      o_bk_w_last[i]  = (w_cnt >= w_len - 8'(N - 1));
    end
  end

  // Each bank answers once per burst, held off until the merged B leaves
  assign o_bk_b_ready = ~b_done;
  assign o_b_valid    = &b_done;
  assign o_b_resp     = resp_q;
  assign b_fire       = o_b_valid && i_b_ready;

  always_ff @(posedge clk) begin
    if (i_rst || b_fire) begin
      b_done <= '0;
      resp_q <= stripe_pkg::OKAY;
    end else begin
      b_done <= b_done | i_bk_b_valid;
      for (int i = 0; i < N; i++) begin
        if (i_bk_b_valid[i] && !b_done[i] && i_bk_b_resp[i] == stripe_pkg::SLVERR) begin
          resp_q <= stripe_pkg::SLVERR;
        end
      end
    end
  end

  burst_fifo #(
    .payload_t(stripe_pkg::id_t)
  ) id_fifo_i (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_push     (aw_fire),
    .i_push_data(i_aw_id),
    .i_pop      (b_fire),
    .o_head     (o_b_id),
    .o_empty    (fifo_empty),
    .o_full     (fifo_full)
  );

  a_aw_aligned : assert property (@(posedge clk) disable iff (i_rst)
    i_aw_valid |-> (i_aw_addr[SEL_W-1:0] == '0) && (i_aw_len[SEL_W-1:0] == '1));

  a_w_last : assert property (@(posedge clk) disable iff (i_rst)
    w_fire |-> (i_w_last == (w_cnt == w_len)));

  // A merged B always belongs to a recorded burst
  a_b_has_id : assert property (@(posedge clk) disable iff (i_rst)
    o_b_valid |-> !fifo_empty);

endmodule

// File: sim.f
+incdir+include
logic/stripe_pkg.sv
logic/burst_fifo.sv
logic/stripe_wr.sv
logic/stripe_rd.sv
logic/bank_mem.sv
logic/stripe_top.sv
tb/stripe_tb.sv

// File: tb/stripe_tb.sv
module stripe_tb;

  localparam int NUM_ENTRIES = 6;
  localparam int TIMEOUT     = 200;
  localparam int MEM_WORDS   = 1 << $bits(stripe_pkg::addr_t);

  logic                clk;
  logic                i_rst;
  logic                i_aw_valid;
  stripe_pkg::addr_t   i_aw_addr;
  stripe_pkg::id_t     i_aw_id;
  stripe_pkg::len_t    i_aw_len;
  logic                o_aw_ready;
  logic                i_w_valid;
  stripe_pkg::data_t   i_w_data;
  logic                i_w_last;
  logic                o_w_ready;
  logic                o_b_valid;
  stripe_pkg::id_t     o_b_id;
  stripe_pkg::resp_t   o_b_resp;
  logic                i_b_ready;
  logic                i_ar_valid;
  stripe_pkg::addr_t   i_ar_addr;
  stripe_pkg::id_t     i_ar_id;
  stripe_pkg::len_t    i_ar_len;
  logic                o_ar_ready;
  logic                o_r_valid;
  stripe_pkg::data_t   o_r_data;
  stripe_pkg::id_t     o_r_id;
  logic                o_r_last;
  logic                i_r_ready;

  integer              seed;

  // Expected memory contents, indexed by manager word address
  stripe_pkg::data_t   shadow[MEM_WORDS];

  // Burst table: start address, id, beats minus one
  // Entry 3 overlaps entries 1 and 2 and runs over the banks many times
  stripe_pkg::addr_t tbl_addr[NUM_ENTRIES] = '{8'h00, 8'h10, 8'h24, 8'h08, 8'h40, 8'hf0};
  stripe_pkg::id_t   tbl_id[NUM_ENTRIES]   = '{4'h3, 4'h9, 4'h5, 4'hc, 4'h1, 4'ha};
  stripe_pkg::len_t  tbl_len[NUM_ENTRIES]  = '{8'd3, 8'd7, 8'd11, 8'd31, 8'd3, 8'd15};

  stripe_top dut_i (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_aw_valid(i_aw_valid),
    .i_aw_addr (i_aw_addr),
    .i_aw_id   (i_aw_id),
    .i_aw_len  (i_aw_len),
    .o_aw_ready(o_aw_ready),
    .i_w_valid (i_w_valid),
    .i_w_data  (i_w_data),
    .i_w_last  (i_w_last),
    .o_w_ready (o_w_ready),
    .o_b_valid (o_b_valid),
    .o_b_id    (o_b_id),
    .o_b_resp  (o_b_resp),
    .i_b_ready (i_b_ready),
    .i_ar_valid(i_ar_valid),
    .i_ar_addr (i_ar_addr),
    .i_ar_id   (i_ar_id),
    .i_ar_len  (i_ar_len),
    .o_ar_ready(o_ar_ready),
    .o_r_valid (o_r_valid),
    .o_r_data  (o_r_data),
    .o_r_id    (o_r_id),
    .o_r_last  (o_r_last),
    .i_r_ready (i_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input stripe_pkg::data_t got,
                            input stripe_pkg::data_t exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_id(input string name, input stripe_pkg::id_t got,
                          input stripe_pkg::id_t exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input stripe_pkg::resp_t got,
                            input stripe_pkg::resp_t exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_last(input string name, input bit got, input bit exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  // Inputs change a little after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic write_burst(input int e);
    int t;
    int k;
    stripe_pkg::data_t val;
    i_aw_valid = 1'b1;
    i_aw_addr  = tbl_addr[e];
    i_aw_id    = tbl_id[e];
    i_aw_len   = tbl_len[e];
    t = 0;
    @(negedge clk);
    while (!o_aw_ready) begin
      t++;
      if (t > TIMEOUT) report_fail("Timeout waiting for write address handshake");
      @(negedge clk);
    end
    tick();
    i_aw_valid = 1'b0;
    for (k = 0; k <= int'(tbl_len[e]); k++) begin
      val = stripe_pkg::data_t'($random(seed));
      shadow[int'(tbl_addr[e]) + k] = val;
      i_w_valid = 1'b1;
      i_w_data  = val;
      i_w_last  = (k == int'(tbl_len[e]));
      t = 0;
      @(negedge clk);
      while (!o_w_ready) begin
        t++;
        if (t > TIMEOUT) report_fail("Timeout waiting for write data ready");
        @(negedge clk);
      end
      tick();
    end
    i_w_valid = 1'b0;
    i_w_last  = 1'b0;
    // Response taken with random gaps in i_b_ready
    t = 0;
    i_b_ready = 1'($random(seed));
    @(negedge clk);
    while (!(o_b_valid && i_b_ready)) begin
      t++;
      if (t > TIMEOUT) report_fail("Timeout waiting for write response");
      tick();
      i_b_ready = 1'($random(seed));
      @(negedge clk);
    end
    check_id("o_b_id", o_b_id, tbl_id[e]);
    check_resp("o_b_resp", o_b_resp, stripe_pkg::OKAY);
    tick();
    i_b_ready = 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (o_b_valid) report_fail("Second write response seen for a single burst");
    end
    tick();
  endtask

  task automatic send_ar(input int e);
    int t;
    i_ar_valid = 1'b1;
    i_ar_addr  = tbl_addr[e];
    i_ar_id    = tbl_id[e];
    i_ar_len   = tbl_len[e];
    t = 0;
    @(negedge clk);
    while (!o_ar_ready) begin
      t++;
      if (t > TIMEOUT) report_fail("Timeout waiting for read address handshake");
      @(negedge clk);
    end
    tick();
    i_ar_valid = 1'b0;
  endtask

  // Collects one read burst, optionally with random i_r_ready gaps
  task automatic recv_r(input int e, input bit stall);
    int t;
    int k;
    bit held;
    stripe_pkg::data_t held_data;
    k = 0;
    t = 0;
    held = 1'b0;
    held_data = '0;
    while (k <= int'(tbl_len[e])) begin
      i_r_ready = stall ? (2'($random(seed)) != 2'd0) : 1'b1;
      @(negedge clk);
      // A stalled beat must stay put
      if (held) begin
        if (!o_r_valid) report_fail("Read beat dropped while stalled");
        check_data("o_r_data", o_r_data, held_data);
      end
      held      = o_r_valid && !i_r_ready;
      held_data = o_r_data;
      if (o_r_valid && i_r_ready) begin
        check_data("o_r_data", o_r_data, shadow[int'(tbl_addr[e]) + k]);
        check_id("o_r_id", o_r_id, tbl_id[e]);
        check_last("o_r_last", o_r_last, k == int'(tbl_len[e]));
        k++;
        t = 0;
      end else begin
        t++;
        if (t > TIMEOUT) report_fail("Timeout waiting for read data");
      end
      tick();
    end
    i_r_ready = 1'b0;
  endtask

  initial begin
    seed       = 32'hc82a0b68;
    i_rst      = 1'b1;
    i_aw_valid = 1'b0;
    i_aw_addr  = '0;
    i_aw_id    = '0;
    i_aw_len   = '0;
    i_w_valid  = 1'b0;
    i_w_data   = '0;
    i_w_last   = 1'b0;
    i_b_ready  = 1'b0;
    i_ar_valid = 1'b0;
    i_ar_addr  = '0;
    i_ar_id    = '0;
    i_ar_len   = '0;
    i_r_ready  = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = '0;
    end

    repeat (3) @(posedge clk);
    #2;
    i_rst = 1'b0;
    @(negedge clk);
    if (o_b_valid || o_r_valid || o_aw_ready || o_ar_ready)
      report_fail("Valid or ready output high straight after reset");
    tick();

    for (int e = 0; e < NUM_ENTRIES; e++) begin
      write_burst(e);
    end

    // First read without back-pressure, the rest with it
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      send_ar(e);
      recv_r(e, e != 0);
    end

    // Two bursts in flight before any beat is taken
    i_r_ready = 1'b0;
    send_ar(1);
    send_ar(4);
    recv_r(1, 1'b1);
    recv_r(4, 1'b1);

    $display("NO ERRORS");
    $finish;
  end

endmodule
